/* design/manycore_pkg.sv */
`default_nettype none

package manycore_pkg;

  // grid geometry
  localparam int num_rows  = 2;
  localparam int num_cols  = 2;
  localparam int num_tiles = num_rows * num_cols;

  // program image
  localparam int img_words       = 16;    // 32-bit words per image
  localparam int tile_id_ptr     = 3;     // word patched with the tile number
  localparam int checksum_cycles = img_words; // one word summed per cycle

  typedef logic [31:0] word_t;
  typedef logic [3:0]  waddr_t;
  typedef logic [0:0]  xcord_t;
  typedef logic [0:0]  ycord_t;
  typedef logic [1:0]  tile_idx_t;

  typedef enum logic [1:0] {
    op_store    = 2'd1,  // write one word into tile memory
    op_unfreeze = 2'd2   // release the tile
  } opcode_e;

  typedef enum logic [1:0] {
    idle,
    load,
    unfreeze,
    done
  } loader_state_e;

  typedef enum logic [1:0] {
    frozen,
    running,
    reporting,
    finished
  } tile_state_e;

  // tile number to grid position, row-major
  function automatic xcord_t tile_xcord(input tile_idx_t tile);
    return xcord_t'(int'(tile) % num_cols);
  endfunction

  function automatic ycord_t tile_ycord(input tile_idx_t tile);
    return ycord_t'(int'(tile) / num_cols);
  endfunction

endpackage

`default_nettype wire

/* design/tile_link_if.sv */
`default_nettype none

interface tile_link_if;

  logic                   valid;
  logic                   ready;
  manycore_pkg::opcode_e  opcode;
  manycore_pkg::waddr_t   word_addr;
  manycore_pkg::word_t    data;
  manycore_pkg::xcord_t   xcord;   // destination column
  manycore_pkg::ycord_t   ycord;   // destination row

  modport source (
    output valid, opcode, word_addr, data, xcord, ycord,
    input  ready
  );

  modport sink (
    input  valid, opcode, word_addr, data, xcord, ycord,
    output ready
  );

endinterface

`default_nettype wire

/* design/result_link_if.sv */
`default_nettype none

interface result_link_if;

  logic                    valid;
  logic                    ready;
  manycore_pkg::tile_idx_t tile;  // reporting tile
  manycore_pkg::word_t     sum;   // checksum of its memory

  modport source (
    output valid, tile, sum,
    input  ready
  );

  modport sink (
    input  valid, tile, sum,
    output ready
  );

endinterface

`default_nettype wire

/* design/spmd_loader.sv */
`default_nettype none

module spmd_loader (
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  logic                 img_we_i,
  input  manycore_pkg::waddr_t img_addr_i,
  input  manycore_pkg::word_t  img_data_i,
  input  logic                 start_i,
  output logic                 busy_o,
  output logic                 done_o,
  tile_link_if.source          pkt_o
);

  manycore_pkg::loader_state_e state;
  manycore_pkg::tile_idx_t     tile_no;   // tile being served
  manycore_pkg::waddr_t        load_addr; // word being sent
  manycore_pkg::word_t         img_mem [manycore_pkg::img_words];

  logic xfer;
  logic last_word;
  logic last_tile;

  assign xfer      = pkt_o.valid & pkt_o.ready;
  assign last_word = (load_addr == manycore_pkg::waddr_t'(manycore_pkg::img_words - 1));
  assign last_tile = (tile_no == manycore_pkg::tile_idx_t'(manycore_pkg::num_tiles - 1));

  // host side image buffer, frozen once a launch begins
  always_ff @(posedge clk_i)
  begin
    if (img_we_i && state == manycore_pkg::idle)
      img_mem[img_addr_i] <= img_data_i;
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      state     <= manycore_pkg::idle;
      tile_no   <= '0;
      load_addr <= '0;
    end
    else
    begin
      case (state)
        manycore_pkg::idle:
          if (start_i)
          begin
            state     <= manycore_pkg::load;
            tile_no   <= '0;
            load_addr <= '0;
          end
        manycore_pkg::load:
          if (xfer)
          begin
            load_addr <= last_word ? '0 : load_addr + 1'b1;
            if (last_word)
            begin
              tile_no <= last_tile ? '0 : tile_no + 1'b1;
              if (last_tile)
                state <= manycore_pkg::unfreeze; // every image copied
            end
          end
        manycore_pkg::unfreeze:
          if (xfer)
          begin
            tile_no <= tile_no + 1'b1;
            if (last_tile)
              state <= manycore_pkg::done;
          end
        default: ; // done holds until reset
      endcase
    end
  end

  assign busy_o = (state == manycore_pkg::load) || (state == manycore_pkg::unfreeze);
  assign done_o = (state == manycore_pkg::done);

  assign pkt_o.valid     = busy_o;
  assign pkt_o.opcode    = (state == manycore_pkg::unfreeze) ? manycore_pkg::op_unfreeze
                                                             : manycore_pkg::op_store;
  assign pkt_o.word_addr = load_addr;
  assign pkt_o.xcord     = manycore_pkg::tile_xcord(tile_no);
  assign pkt_o.ycord     = manycore_pkg::tile_ycord(tile_no);

  always_comb
  begin
    if (state == manycore_pkg::unfreeze)
      pkt_o.data = '0;
    else if (load_addr == manycore_pkg::waddr_t'(manycore_pkg::tile_id_ptr))
      pkt_o.data = manycore_pkg::word_t'(tile_no); // per-tile id patch
    else
      pkt_o.data = img_mem[load_addr];
  end

  // a stalled packet must not change under the tile
  a_pkt_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    pkt_o.valid && !pkt_o.ready |=>
      pkt_o.valid && $stable(pkt_o.opcode) && $stable(pkt_o.word_addr) &&
      $stable(pkt_o.data) && $stable(pkt_o.xcord) && $stable(pkt_o.ycord))
    else $error("loader packet changed while stalled");

endmodule

`default_nettype wire

/* design/packet_router.sv */
`default_nettype none

module packet_router (
  tile_link_if.sink   up_i,
  tile_link_if.source down_o [manycore_pkg::num_tiles]
);

  int                                  dest_idx;   // row-major tile number
  logic [manycore_pkg::num_tiles-1:0]  tile_sel;   // one-hot destination
  logic [manycore_pkg::num_tiles-1:0]  tile_ready;

  assign dest_idx = int'(up_i.ycord) * manycore_pkg::num_cols + int'(up_i.xcord);

  for (genvar g = 0; g < manycore_pkg::num_tiles; g++)
  begin : g_port
    assign tile_sel[g] = (dest_idx == g);

    // fields fan out to all tiles, only valid is steered
    assign down_o[g].valid     = up_i.valid & tile_sel[g];
    assign down_o[g].opcode    = up_i.opcode;
    assign down_o[g].word_addr = up_i.word_addr;
    assign down_o[g].data      = up_i.data;
    assign down_o[g].xcord     = up_i.xcord;
    assign down_o[g].ycord     = up_i.ycord;

    assign tile_ready[g] = down_o[g].ready;
  end

  // back-pressure from the addressed tile only
  assign up_i.ready = |(tile_ready & tile_sel);

  // decoded tile must lie inside the grid
  always_comb
  begin
    if (up_i.valid)
    begin
      assert (dest_idx < manycore_pkg::num_tiles)
        else $error("packet addressed outside the grid (%0d)", dest_idx);
    end
  end

endmodule

`default_nettype wire

/* design/tile_node.sv */
`default_nettype none

module tile_node (
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  manycore_pkg::tile_idx_t tile_id_i,
  tile_link_if.sink               pkt_i,
  result_link_if.source           res_o
);

  manycore_pkg::tile_state_e state;
  manycore_pkg::waddr_t      rd_addr;  // summing pointer
  manycore_pkg::word_t       sum;      // running checksum
  manycore_pkg::word_t       mem [manycore_pkg::img_words];

  logic pkt_xfer;
  logic sum_last;

  assign pkt_xfer = pkt_i.valid & pkt_i.ready;
  assign sum_last = (rd_addr == manycore_pkg::waddr_t'(manycore_pkg::checksum_cycles - 1));

  // local program memory, filled only while frozen
  always_ff @(posedge clk_i)
  begin
    if (pkt_xfer && pkt_i.opcode == manycore_pkg::op_store)
      mem[pkt_i.word_addr] <= pkt_i.data;
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      state   <= manycore_pkg::frozen;
      rd_addr <= '0;
      sum     <= '0;
    end
    else
    begin
      case (state)
        manycore_pkg::frozen:
          if (pkt_xfer && pkt_i.opcode == manycore_pkg::op_unfreeze)
          begin
            state   <= manycore_pkg::running;
            rd_addr <= '0;
            sum     <= '0;
          end
        manycore_pkg::running:
        begin
          sum     <= sum + mem[rd_addr];   // wraps mod 2^32
          rd_addr <= rd_addr + 1'b1;
          if (sum_last)
            state <= manycore_pkg::reporting;
        end
        manycore_pkg::reporting:
          if (res_o.ready)
            state <= manycore_pkg::finished; // result taken
        default: ; // finished until reset
      endcase
    end
  end

  assign pkt_i.ready = (state == manycore_pkg::frozen);

  assign res_o.valid = (state == manycore_pkg::reporting);
  assign res_o.tile  = tile_id_i;
  assign res_o.sum   = sum;

  // router decode must agree with this tile's grid position
  a_coord_match: assert property (@(posedge clk_i) disable iff (reset_i)
    pkt_i.valid |-> (pkt_i.xcord == manycore_pkg::tile_xcord(tile_id_i)) &&
                    (pkt_i.ycord == manycore_pkg::tile_ycord(tile_id_i)))
    else $error("tile %0d got a packet for another tile", tile_id_i);

endmodule

`default_nettype wire

/* design/result_collector.sv */
`default_nettype none

module result_collector (
  input  logic                    clk_i,
  input  logic                    reset_i,
  result_link_if.sink             res_i [manycore_pkg::num_tiles],
  output logic                    result_valid_o,
  input  logic                    result_ready_i,
  output manycore_pkg::tile_idx_t result_tile_o,
  output manycore_pkg::word_t     result_sum_o
);

  logic [manycore_pkg::num_tiles-1:0] req;
  logic [manycore_pkg::num_tiles-1:0] grant;
  manycore_pkg::tile_idx_t            req_tile [manycore_pkg::num_tiles];
  manycore_pkg::word_t                req_sum  [manycore_pkg::num_tiles];

  manycore_pkg::tile_idx_t last_q;  // last tile granted
  manycore_pkg::tile_idx_t pick;
  logic                    found;
  logic                    can_load; // output slot free or draining

  for (genvar g = 0; g < manycore_pkg::num_tiles; g++)
  begin : g_gather
    assign req[g]       = res_i[g].valid;
    assign req_tile[g]  = res_i[g].tile;
    assign req_sum[g]   = res_i[g].sum;
    assign res_i[g].ready = grant[g];
    assign grant[g]     = can_load & found & (pick == manycore_pkg::tile_idx_t'(g));
  end

  assign can_load = ~result_valid_o | result_ready_i;

  // first requester after last_q, wrapping around
  always_comb
  begin
    manycore_pkg::tile_idx_t cand;
    pick  = '0;
    found = 1'b0;
    for (int k = 1; k <= manycore_pkg::num_tiles; k++)
    begin
      cand = manycore_pkg::tile_idx_t'((int'(last_q) + k) % manycore_pkg::num_tiles);
      if (!found && req[cand])
      begin
        pick  = cand;
        found = 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      result_valid_o <= 1'b0;
      last_q         <= manycore_pkg::tile_idx_t'(manycore_pkg::num_tiles - 1); // tile 0 first
    end
    else if (can_load)
    begin
      result_valid_o <= found;
      if (found)
        last_q <= pick;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (can_load && found)
    begin
      result_tile_o <= req_tile[pick];
      result_sum_o  <= req_sum[pick];
    end
  end

  a_one_grant: assert property (@(posedge clk_i) disable iff (reset_i) $onehot0(grant))
    else $error("more than one tile result accepted in a cycle");

endmodule

`default_nettype wire

/* design/manycore_top.sv */
`default_nettype none

module manycore_top (
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  logic                    img_we_i,
  input  manycore_pkg::waddr_t    img_addr_i,
  input  manycore_pkg::word_t     img_data_i,
  input  logic                    start_i,
  output logic                    busy_o,
  output logic                    done_o,
  output logic                    result_valid_o,
  input  logic                    result_ready_i,
  output manycore_pkg::tile_idx_t result_tile_o,
  output manycore_pkg::word_t     result_sum_o
);

  tile_link_if   up_link ();                               // loader to router
  tile_link_if   tile_link [manycore_pkg::num_tiles] ();   // router to tiles
  result_link_if res_link  [manycore_pkg::num_tiles] ();   // tiles to collector

  spmd_loader u_loader (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .img_we_i   (img_we_i),
    .img_addr_i (img_addr_i),
    .img_data_i (img_data_i),
    .start_i    (start_i),
    .busy_o     (busy_o),
    .done_o     (done_o),
    .pkt_o      (up_link)
  );

  packet_router u_router (
    .up_i   (up_link),
    .down_o (tile_link)
  );

  for (genvar t = 0; t < manycore_pkg::num_tiles; t++)
  begin : g_tile
    tile_node u_tile (
      .clk_i     (clk_i),
      .reset_i   (reset_i),
      .tile_id_i (manycore_pkg::tile_idx_t'(t)),
      .pkt_i     (tile_link[t]),
      .res_o     (res_link[t])
    );
  end

  result_collector u_collector (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .res_i          (res_link),
    .result_valid_o (result_valid_o),
    .result_ready_i (result_ready_i),
    .result_tile_o  (result_tile_o),
    .result_sum_o   (result_sum_o)
  );

endmodule

`default_nettype wire

/* test/tb_manycore.sv */
`default_nettype none

module tb_manycore;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int num_runs     = 3;
  localparam int reset_cycles = 8;
  localparam int pkt_count    = manycore_pkg::num_tiles * (manycore_pkg::img_words + 1); // 68
  localparam int run_cycles   = reset_cycles + manycore_pkg::img_words + pkt_count +
                                manycore_pkg::checksum_cycles + 8 * manycore_pkg::num_tiles + 16;
  localparam int watchdog_cycles = 4 * num_runs * run_cycles; // margin for ready stalls

  logic                    clk_i;
  logic                    reset_i;
  logic                    img_we_i;
  manycore_pkg::waddr_t    img_addr_i;
  manycore_pkg::word_t     img_data_i;
  logic                    start_i;
  logic                    busy_o;
  logic                    done_o;
  logic                    result_valid_o;
  logic                    result_ready_i;
  manycore_pkg::tile_idx_t result_tile_o;
  manycore_pkg::word_t     result_sum_o;

  manycore_pkg::word_t img_model [manycore_pkg::img_words]; // image as written while idle
  int mismatch_count;
  int other_count;

  manycore_top u_manycore_top (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .img_we_i       (img_we_i),
    .img_addr_i     (img_addr_i),
    .img_data_i     (img_data_i),
    .start_i        (start_i),
    .busy_o         (busy_o),
    .done_o         (done_o),
    .result_valid_o (result_valid_o),
    .result_ready_i (result_ready_i),
    .result_tile_o  (result_tile_o),
    .result_sum_o   (result_sum_o)
  );

  initial
  begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  task automatic check_sum(input string name, input manycore_pkg::word_t got,
                           input manycore_pkg::word_t exp);
    if (got !== exp)
    begin
      $display("MISMATCH %s: got %h expected %h", name, got, exp);
      mismatch_count++;
    end
  endtask

  task automatic check_tile(input string name, input manycore_pkg::tile_idx_t got,
                            input manycore_pkg::tile_idx_t exp);
    if (got !== exp)
    begin
      $display("MISMATCH %s: got %h expected %h", name, got, exp);
      mismatch_count++;
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
      $display("MISMATCH %s: got %h expected %h", name, got, exp);
      mismatch_count++;
    end
  endtask

  // image sum with the id word swapped for the tile number, wraps mod 2^32
  function automatic manycore_pkg::word_t model_sum(input manycore_pkg::tile_idx_t tile);
    manycore_pkg::word_t acc;
    acc = '0;
    for (int a = 0; a < manycore_pkg::img_words; a++)
      acc += (a == manycore_pkg::tile_id_ptr) ? manycore_pkg::word_t'(tile) : img_model[a];
    return acc;
  endfunction

  task automatic apply_reset();
    @(negedge clk_i);
    reset_i        = 1'b1;
    img_we_i       = 1'b0;
    start_i        = 1'b0;
    result_ready_i = 1'b0;
    repeat (reset_cycles) @(negedge clk_i);
    check_flag("busy_o", busy_o, 1'b0);
    check_flag("done_o", done_o, 1'b0);
    check_flag("result_valid_o", result_valid_o, 1'b0);
    reset_i = 1'b0;
  endtask

  task automatic load_image();
    for (int a = 0; a < manycore_pkg::img_words; a++)
    begin
      @(negedge clk_i);
      img_model[a] = $urandom();
      img_we_i     = 1'b1;
      img_addr_i   = manycore_pkg::waddr_t'(a);
      img_data_i   = img_model[a];
    end
    @(negedge clk_i);
    img_we_i = 1'b0;
  endtask

  task automatic run_launch(input int run);
    logic [manycore_pkg::num_tiles-1:0] seen;
    int                                 got;
    logic                               hold_q;    // result stalled last cycle
    manycore_pkg::tile_idx_t            hold_tile;
    manycore_pkg::word_t                hold_sum;
    logic                               done_seen;
    seen      = '0;
    got       = 0;
    hold_q    = 1'b0;
    hold_tile = '0;
    hold_sum  = '0;
    done_seen = 1'b0;
    apply_reset();
    load_image();
    check_flag("busy_o", busy_o, 1'b0);
    start_i        = 1'b1;
    result_ready_i = 1'b1;
    @(negedge clk_i);
    start_i = 1'b0;
    check_flag("busy_o", busy_o, 1'b1);
    while (got < manycore_pkg::num_tiles)
    begin
      @(negedge clk_i);
      if (hold_q)
      begin
        check_flag("result_valid_o", result_valid_o, 1'b1);
        check_tile("result_tile_o", result_tile_o, hold_tile);
        check_sum("result_sum_o", result_sum_o, hold_sum);
      end
      if (done_seen)
      begin
        check_flag("done_o", done_o, 1'b1);
        check_flag("busy_o", busy_o, 1'b0);
      end
      else if (done_o)
      begin
        done_seen = 1'b1;
        check_flag("busy_o", busy_o, 1'b0); // falls together with done rising
      end
      // ready for the coming edge, which decides the transfer
      result_ready_i = ($urandom_range(7, 0) != 0);
      if (result_valid_o && result_ready_i)
      begin
        if (seen[result_tile_o])
        begin
          $display("run %0d: tile %0d reported its result twice", run, result_tile_o);
          other_count++;
        end
        seen[result_tile_o] = 1'b1;
        check_sum("result_sum_o", result_sum_o, model_sum(result_tile_o));
        got++;
      end
      hold_q    = result_valid_o && !result_ready_i;
      hold_tile = result_tile_o;
      hold_sum  = result_sum_o;
      // writes during a launch must be ignored by the loader
      img_we_i   = busy_o && ($urandom_range(1, 0) == 1);
      img_addr_i = manycore_pkg::waddr_t'($urandom());
      img_data_i = $urandom();
    end
    img_we_i       = 1'b0;
    result_ready_i = 1'b1;
    check_flag("done_o", done_o, 1'b1);
    repeat (4)
    begin
      @(negedge clk_i);
      check_flag("result_valid_o", result_valid_o, 1'b0); // no fifth result
    end
    if (seen != '1)
    begin
      $display("run %0d: not every tile reported a result", run);
      other_count++;
    end
  endtask

  initial
  begin
    void'($urandom(32'h357b_af7a));
    mismatch_count = 0;
    other_count    = 0;
    reset_i        = 1'b1;
    img_we_i       = 1'b0;
    img_addr_i     = '0;
    img_data_i     = '0;
    start_i        = 1'b0;
    result_ready_i = 1'b0;
    for (int r = 0; r < num_runs; r++)
      run_launch(r);
    $display("errors: %0d mismatches, %0d other failures", mismatch_count, other_count);
    if (mismatch_count == 0 && other_count == 0)
      $display("RESULT: PASS");
    else
      $display("RESULT: FAIL");
    $finish;
  end

  // bounds the whole simulation
  initial
  begin
    repeat (watchdog_cycles) @(posedge clk_i);
    $display("timeout: runs did not finish within %0d cycles", watchdog_cycles);
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

/* flist.f */
design/manycore_pkg.sv
design/tile_link_if.sv
design/result_link_if.sv
design/spmd_loader.sv
design/packet_router.sv
design/tile_node.sv
design/result_collector.sv
design/manycore_top.sv
test/tb_manycore.sv

/* run.sh */
#!/bin/sh
# build and run the manycore loader testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_manycore -Mdir obj_dir -o sim_manycore \
  -f flist.f > build.log 2>&1 \
  && ./obj_dir/sim_manycore > sim.log 2>&1 \
  || { echo "build or simulation error, see build.log and sim.log"; exit 1; }

cat sim.log
grep -q "RESULT: FAIL" sim.log && { echo "simulation failed"; exit 1; }
grep -q "RESULT: PASS" sim.log || { echo "no pass line in sim.log"; exit 1; }
exit 0
